//--- playfield_pkg.sv
/*
 * shared types for the bitmap playfield line generator
 * VRAM is 64K x 16 bit words, colour indices are 8 bit
 * bpp code 3 behaves like 8 bpp
 * cfg fields are expected to stay stable for a whole frame
 */
package playfield_pkg;

    typedef logic [15:0] addr_t;                // VRAM word address
    typedef logic [15:0] word_t;                // VRAM data word
    typedef logic [7:0]  color_t;               // colour index
    typedef logic [10:0] hcount_t;              // horizontal timing count

    // pixel depth code
    typedef enum logic [1:0] {
        BPP_1_ATTR = 2'd0,                      // 1 bpp, fg/bg attribute in same word
        BPP_4      = 2'd1,                      // 4 bpp, 2 words per group
        BPP_8      = 2'd2                       // 8 bpp, 4 words per group
    } bpp_t;

    // 1 bpp word as seen by the expander
    typedef struct packed {
        logic [3:0] fore;                       // colour for set bits
        logic [3:0] back;                       // colour for clear bits
        logic [7:0] pixels;                     // bit 7 is leftmost pixel
    } pf_attr_word_t;

    // one memory word, attribute view or four raw nibbles
    typedef union packed {
        pf_attr_word_t   attr;                  // 1 bpp decode
        logic [3:0][3:0] nib;                   // 4 bpp decode, nib[3] leftmost
    } pf_bitmap_word_u;

    // playfield control, per frame
    typedef struct packed {
        logic   blank;                          // hold line address at start_addr
        addr_t  start_addr;                     // first word of frame
        word_t  line_len;                       // words per display line
        color_t colorbase;                      // XORed into every output index
        bpp_t   bpp;                            // pixel depth
    } pf_cfg_t;

    // one group of eight pixels, fetcher to pixel stage
    typedef struct packed {
        logic  valid;                           // one cycle strobe
        word_t w0;                              // first word, leftmost pixels
        word_t w1;
        word_t w2;
        word_t w3;
    } pf_words_t;

    // single word DMA read request
    typedef struct packed {
        logic  req;                             // hold until ack
        addr_t addr;                            // word to read, hold with req
    } pf_dma_t;

endpackage

//--- pf_fetch.sv
/*
 * VRAM fetch sequencer for display words and single word DMA reads
 * relies on a fixed one cycle VRAM read latency
 * DMA starts only from idle with mem_fetch_i low
 * words_o.valid marks the previously read group, so the last group of a
 * line is never delivered and the fetch window must cover one extra group
 */
`timescale 1ns/10ps

module pf_fetch
    import playfield_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      mem_fetch_i,              // fetch window
    input  logic      mem_fetch_start_i,        // reload running address
    input  logic      end_of_line_i,
    input  logic      end_of_frame_i,
    input  pf_cfg_t   cfg_i,
    input  pf_dma_t   dma_i,
    input  word_t     vram_data_i,              // data for last cycle's address
    input  logic      buf_full_i,               // pixel buffer busy, hold off
    output logic      vram_sel_o,
    output addr_t     vram_addr_o,
    output pf_words_t words_o,
    output logic      dma_ack_o,
    output word_t     dma_word_o
);

    typedef enum logic [3:0] {
        FETCH_IDLE,                             // wait for window or DMA
        FETCH_DMA_WAIT,                         // DMA address on bus
        FETCH_DMA_READ,                         // DMA data back
        FETCH_ADDR,                             // word 0 address out
        FETCH_WAIT,                             // word 1 address out if needed
        FETCH_READ_0,
        FETCH_READ_1,
        FETCH_READ_2,
        FETCH_READ_3
    } fetch_state_t;

    fetch_state_t   state, state_next;
    addr_t          pf_addr, addr_next;         // running display address
    addr_t          line_start;                 // first word of current line
    addr_t          vaddr_next;
    logic           sel_next;
    logic           issue;                      // put pf_addr on bus this cycle
    logic           first_grp, first_next;      // no group read yet this line
    logic           grp_valid, grp_valid_next;
    word_t [3:0]    grp_w, grp_w_next;          // words of group in flight
    logic           dma_ack_next;
    word_t          dma_word_next;
    logic           wide;                       // 8 bpp, code 3 included

    assign wide = cfg_i.bpp[1];

    always_comb begin
        state_next     = state;
        addr_next      = pf_addr;
        vaddr_next     = vram_addr_o;
        sel_next       = 1'b0;
        issue          = 1'b0;
        first_next     = first_grp;
        grp_valid_next = 1'b0;
        grp_w_next     = grp_w;
        dma_ack_next   = 1'b0;
        dma_word_next  = dma_word_o;

        case (state)
            FETCH_IDLE: begin
                if (mem_fetch_i) begin
                    state_next = FETCH_ADDR;
                end else if (dma_i.req && !dma_ack_o) begin    // skip req still up at ack
                    sel_next   = 1'b1;
                    vaddr_next = dma_i.addr;
                    state_next = FETCH_DMA_WAIT;
                end
            end
            FETCH_DMA_WAIT: begin
                state_next = FETCH_DMA_READ;
            end
            FETCH_DMA_READ: begin
                dma_word_next = vram_data_i;
                dma_ack_next  = 1'b1;
                state_next    = FETCH_IDLE;
            end
            FETCH_ADDR: begin
                if (!mem_fetch_i) begin
                    state_next = FETCH_IDLE;            // window over
                end else if (!buf_full_i) begin
                    issue      = 1'b1;                  // word 0
                    state_next = FETCH_WAIT;
                end
            end
            FETCH_WAIT: begin
                issue          = (cfg_i.bpp != BPP_1_ATTR);    // word 1
                grp_valid_next = !first_grp;            // hand over previous group
                first_next     = 1'b0;
                state_next     = FETCH_READ_0;
            end
            FETCH_READ_0: begin
                grp_w_next[0] = vram_data_i;
                if (cfg_i.bpp == BPP_1_ATTR) begin
                    state_next = FETCH_ADDR;
                end else begin
                    issue      = wide;                  // word 2
                    state_next = FETCH_READ_1;
                end
            end
            FETCH_READ_1: begin
                grp_w_next[1] = vram_data_i;
                if (!wide) begin
                    state_next = FETCH_ADDR;            // 4 bpp done
                end else begin
                    issue      = 1'b1;                  // word 3
                    state_next = FETCH_READ_2;
                end
            end
            FETCH_READ_2: begin
                grp_w_next[2] = vram_data_i;
                state_next    = FETCH_READ_3;
            end
            FETCH_READ_3: begin
                grp_w_next[3] = vram_data_i;
                state_next    = FETCH_ADDR;
            end
            default: begin
                state_next = FETCH_IDLE;
            end
        endcase

        if (issue) begin
            sel_next   = 1'b1;
            vaddr_next = pf_addr;
            addr_next  = pf_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= FETCH_IDLE;
            pf_addr     <= '0;
            line_start  <= '0;
            first_grp   <= 1'b0;
            grp_valid   <= 1'b0;
            vram_sel_o  <= 1'b0;
            vram_addr_o <= '0;
            dma_ack_o   <= 1'b0;
        end else begin
            state       <= state_next;
            pf_addr     <= addr_next;
            first_grp   <= first_next;
            grp_valid   <= grp_valid_next;
            vram_sel_o  <= sel_next;
            vram_addr_o <= vaddr_next;
            dma_ack_o   <= dma_ack_next;

            if (mem_fetch_start_i) begin
                pf_addr   <= line_start;                // new line from its start word
                first_grp <= 1'b1;
            end

            if (cfg_i.blank || end_of_frame_i) begin
                line_start <= cfg_i.start_addr;         // frame restart, or held while blank
            end else if (end_of_line_i) begin
                line_start <= line_start + cfg_i.line_len;
            end
        end
    end

    always_ff @(posedge clk) begin
        grp_w      <= grp_w_next;
        dma_word_o <= dma_word_next;
    end

    always_comb begin
        words_o.valid = grp_valid;
        words_o.w0    = grp_w[0];
        words_o.w1    = grp_w[1];
        words_o.w2    = grp_w[2];
        words_o.w3    = grp_w[3];
    end

endmodule

//--- pf_scan_timing.sv
/*
 * scanout window and column counter
 * window opens at H_SCANOUT_BEGIN only inside the fetch window
 * VISIBLE_WIDTH must be a multiple of 8 for the final shift to land on column 7
 */
`timescale 1ns/10ps

module pf_scan_timing
    import playfield_pkg::*;
#(
    parameter int H_SCANOUT_BEGIN = 160,
    parameter int VISIBLE_WIDTH   = 640
) (
    input  logic    clk,
    input  logic    reset_i,
    input  hcount_t h_count_i,
    input  logic    mem_fetch_i,
    input  logic    end_of_line_i,
    output logic    scan_load_o,                // buffer to shifter
    output logic    scan_shift_o                // shift one pixel
);

    localparam hcount_t START_H = hcount_t'(H_SCANOUT_BEGIN);
    localparam hcount_t END_H   = hcount_t'(H_SCANOUT_BEGIN + VISIBLE_WIDTH);

    logic       window;                         // pixels being shown
    logic [2:0] col;                            // column within group
    logic       scan_start;
    logic       scan_end;                       // last pixel leaves this cycle

    assign scan_start = mem_fetch_i && (h_count_i == START_H);
    assign scan_end   = window && (h_count_i == END_H);

    // last column of a group reloads, except at window end where border shifts in
    assign scan_load_o  = scan_start || (window && (col == 3'd7) && !scan_end);
    assign scan_shift_o = window && ((col != 3'd7) || scan_end);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            window <= 1'b0;
            col    <= '0;
        end else if (end_of_line_i || scan_end) begin
            window <= 1'b0;
        end else if (scan_start) begin
            window <= 1'b1;
            col    <= '0;
        end else if (window) begin
            col    <= col + 1'b1;                   // wraps every 8 pixels
        end
    end

endmodule

//--- pf_pixel_out.sv
/*
 * pixel buffer, depth expansion and output shifter
 * holds one expanded group waiting and one group shifting out
 * shows border_color_i whenever no loaded pixel is left in the shifter
 * all output indices are XORed with cfg_i.colorbase
 */
`timescale 1ns/10ps

module pf_pixel_out
    import playfield_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  pf_words_t words_i,                  // group from fetcher
    input  pf_cfg_t   cfg_i,
    input  color_t    border_color_i,
    input  logic      mem_fetch_start_i,        // new line, drop leftovers
    input  logic      scan_load_i,
    input  logic      scan_shift_i,
    output logic      buf_full_o,
    output color_t    pf_color_index_o
);

    pf_bitmap_word_u w0_u;                      // word 0 in both views
    logic [63:0]     expanded;                  // eight 8 bit indices, leftmost on top
    logic [63:0]     pix_buf;                   // next group
    logic [63:0]     pix_shift;                 // group on screen
    logic [3:0]      pix_left;                  // loaded pixels still in shifter
    color_t          lead_pix;

    always_comb begin
        w0_u = words_i.w0;
        case (cfg_i.bpp)
            BPP_1_ATTR: begin
                for (int i = 0; i < 8; i++) begin
                    expanded[8*i +: 8] = {4'h0, w0_u.attr.pixels[i] ?
                                                w0_u.attr.fore : w0_u.attr.back};
                end
            end
            BPP_4: begin
                expanded = {4'h0, w0_u.nib[3], 4'h0, w0_u.nib[2],
                            4'h0, w0_u.nib[1], 4'h0, w0_u.nib[0],
                            4'h0, words_i.w1[15:12], 4'h0, words_i.w1[11:8],
                            4'h0, words_i.w1[7:4],   4'h0, words_i.w1[3:0]};
            end
            default: begin
                expanded = {words_i.w0, words_i.w1, words_i.w2, words_i.w3};   // high byte first
            end
        endcase
    end

    // control flags
    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_full_o <= 1'b0;
            pix_left   <= '0;
        end else begin
            if (scan_load_i) begin
                buf_full_o <= 1'b0;             // buffer taken
                pix_left   <= 4'd8;
            end else if (scan_shift_i && (pix_left != '0)) begin
                pix_left   <= pix_left - 1'b1;
            end
            if (words_i.valid) begin
                buf_full_o <= 1'b1;             // wins over a load in the same cycle
            end
            if (mem_fetch_start_i) begin
                buf_full_o <= 1'b0;
                pix_left   <= '0;
            end
        end
    end

    // pixel data
    always_ff @(posedge clk) begin
        if (scan_load_i) begin
            pix_shift <= pix_buf;
        end else if (scan_shift_i) begin
            pix_shift <= {pix_shift[55:0], border_color_i};
        end
        if (words_i.valid) begin
            pix_buf <= expanded;
        end
    end

    assign lead_pix         = (pix_left != '0) ? pix_shift[63:56] : border_color_i;
    assign pf_color_index_o = lead_pix ^ cfg_i.colorbase;

endmodule

//--- playfield_top.sv
/*
 * bitmap playfield line generator, top level
 * VISIBLE_WIDTH must be a multiple of 8
 * vram_data_i must follow vram_sel_o/vram_addr_o by exactly one cycle
 * pixel x appears the cycle after h_count_i == H_SCANOUT_BEGIN + x
 */
`timescale 1ns/10ps

module playfield_top
    import playfield_pkg::*;
#(
    parameter int H_SCANOUT_BEGIN = 160,        // h count of first visible pixel
    parameter int VISIBLE_WIDTH   = 640         // pixels per line
) (
    input  logic      clk,
    input  logic      reset_i,
    input  hcount_t   h_count_i,                // horizontal timing count
    input  logic      mem_fetch_i,              // line fetch window
    input  logic      mem_fetch_start_i,        // strobe at window start
    input  logic      end_of_line_i,            // strobe
    input  logic      end_of_frame_i,           // strobe
    input  color_t    border_color_i,
    input  pf_cfg_t   cfg_i,                    // stable during frame
    input  pf_dma_t   dma_i,
    input  word_t     vram_data_i,
    output logic      vram_sel_o,
    output addr_t     vram_addr_o,
    output logic      dma_ack_o,                // one cycle pulse
    output word_t     dma_word_o,               // valid from ack on
    output color_t    pf_color_index_o
);

    pf_words_t words;                           // fetched group to pixel stage
    logic      buf_full;                        // pixel buffer occupied
    logic      scan_load;                       // buffer to shifter
    logic      scan_shift;                      // next pixel

    pf_fetch pf_fetch_inst (
        .clk               (clk),
        .reset_i           (reset_i),
        .mem_fetch_i       (mem_fetch_i),
        .mem_fetch_start_i (mem_fetch_start_i),
        .end_of_line_i     (end_of_line_i),
        .end_of_frame_i    (end_of_frame_i),
        .cfg_i             (cfg_i),
        .dma_i             (dma_i),
        .vram_data_i       (vram_data_i),
        .buf_full_i        (buf_full),
        .vram_sel_o        (vram_sel_o),
        .vram_addr_o       (vram_addr_o),
        .words_o           (words),
        .dma_ack_o         (dma_ack_o),
        .dma_word_o        (dma_word_o)
    );

    pf_scan_timing #(
        .H_SCANOUT_BEGIN (H_SCANOUT_BEGIN),
        .VISIBLE_WIDTH   (VISIBLE_WIDTH)
    ) pf_scan_timing_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .h_count_i     (h_count_i),
        .mem_fetch_i   (mem_fetch_i),
        .end_of_line_i (end_of_line_i),
        .scan_load_o   (scan_load),
        .scan_shift_o  (scan_shift)
    );

    pf_pixel_out pf_pixel_out_inst (
        .clk               (clk),
        .reset_i           (reset_i),
        .words_i           (words),
        .cfg_i             (cfg_i),
        .border_color_i    (border_color_i),
        .mem_fetch_start_i (mem_fetch_start_i),
        .scan_load_i       (scan_load),
        .scan_shift_i      (scan_shift),
        .buf_full_o        (buf_full),
        .pf_color_index_o  (pf_color_index_o)
    );

endmodule

//--- tb_clock_gen.sv
/*
 * testbench clock and reset source
 * reset_o is held high for RESET_CYCLES rising edges, released 1 ns after an edge
 */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 4.0,          // clock period
    parameter int  RESET_CYCLES = 3             // edges with reset high
) (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_o = 1'b0;                      // same 1 ns offset as stimulus
    end

endmodule

//--- playfield_checker.sv
/*
 * protocol assertions for playfield_top, attached with bind
 * sampled on the rising clock edge
 */
`timescale 1ns/10ps

module playfield_checker (
    input logic clk,
    input logic reset_i,
    input logic mem_fetch_i,
    input logic vram_sel_o,
    input logic dma_ack_o
);

    // ack is a single cycle pulse
    a_ack_single: assert property (@(posedge clk) disable iff (reset_i)
        dma_ack_o |=> !dma_ack_o)
        else $error("dma_ack_o high for two cycles");

    // bus idle right after reset
    a_sel_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |-> !vram_sel_o)
        else $error("vram_sel_o high in first cycle after reset");

    // DMA only outside the line fetch window
    a_no_ack_in_fetch: assert property (@(posedge clk) disable iff (reset_i)
        dma_ack_o |-> !mem_fetch_i)
        else $error("dma_ack_o while mem_fetch_i high");

endmodule

bind playfield_top playfield_checker checker_inst (
    .clk         (clk),
    .reset_i     (reset_i),
    .mem_fetch_i (mem_fetch_i),
    .vram_sel_o  (vram_sel_o),
    .dma_ack_o   (dma_ack_o)
);

//--- playfield_tb.sv
/*
 * testbench for playfield_top with small timing of 80 cycles per line
 * fetch window h 1..57, fetch start at h 0, end of line at h 79
 * a frame start is one extra cycle with end_of_frame high
 * VRAM model is 4K words, addresses above that wrap
 */
`timescale 1ns/10ps

module playfield_tb
    import playfield_pkg::*;
();

    localparam int H_BEGIN     = 24;
    localparam int VIS_W       = 32;
    localparam int LINE_CYC    = 80;
    localparam int TOTAL_LINES = 12;
    localparam int LIMIT       = TOTAL_LINES * LINE_CYC + 200;

    logic      clk;
    logic      reset_i;
    hcount_t   h_count_i;
    logic      mem_fetch_i;
    logic      mem_fetch_start_i;
    logic      end_of_line_i;
    logic      end_of_frame_i;
    color_t    border_color_i;
    pf_cfg_t   cfg_i;
    pf_dma_t   dma_i;
    word_t     vram_data_i;
    logic      vram_sel_o;
    addr_t     vram_addr_o;
    logic      dma_ack_o;
    word_t     dma_word_o;
    color_t    pf_color_index_o;

    word_t     mem [0:4095];                    // VRAM contents
    integer    seed;
    int        n_errors;
    int        n_checks;
    int        cycles;
    int        ack_count;
    int        cur_h;                           // h of the current cycle
    addr_t     line_addr;                       // expected first word of line
    logic      checking;

    tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(3)) tb_clock_gen_inst (
        .clk     (clk),
        .reset_o (reset_i)
    );

    playfield_top #(
        .H_SCANOUT_BEGIN (H_BEGIN),
        .VISIBLE_WIDTH   (VIS_W)
    ) playfield_top_inst (
        .clk               (clk),
        .reset_i           (reset_i),
        .h_count_i         (h_count_i),
        .mem_fetch_i       (mem_fetch_i),
        .mem_fetch_start_i (mem_fetch_start_i),
        .end_of_line_i     (end_of_line_i),
        .end_of_frame_i    (end_of_frame_i),
        .border_color_i    (border_color_i),
        .cfg_i             (cfg_i),
        .dma_i             (dma_i),
        .vram_data_i       (vram_data_i),
        .vram_sel_o        (vram_sel_o),
        .vram_addr_o       (vram_addr_o),
        .dma_ack_o         (dma_ack_o),
        .dma_word_o        (dma_word_o),
        .pf_color_index_o  (pf_color_index_o)
    );

    // one cycle read latency
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= #1 mem[vram_addr_o[11:0]];
        end
    end

    // expected index of visible pixel x
    function automatic color_t expected_color(addr_t base, pf_cfg_t cfg, int x);
        word_t  w;
        color_t c;
        case (cfg.bpp)
            BPP_1_ATTR: begin
                w = mem[12'(base + addr_t'(x / 8))];
                c = w[7 - (x % 8)] ? {4'h0, w[15:12]} : {4'h0, w[11:8]};
            end
            BPP_4: begin
                w = mem[12'(base + addr_t'(x / 4))];
                c = {4'h0, 4'(w >> (12 - 4 * (x % 4)))};
            end
            default: begin
                w = mem[12'(base + addr_t'(x / 2))];
                c = (x % 2 == 0) ? w[15:8] : w[7:0];   // high byte first
            end
        endcase
        return c ^ cfg.colorbase;
    endfunction

    task automatic check_color(input string name, input color_t got, input color_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // compare every cycle on the falling edge
    always @(negedge clk) begin
        if (checking) begin
            if (cur_h >= H_BEGIN + 1 && cur_h <= H_BEGIN + VIS_W) begin
                check_color("pf_color_index_o", pf_color_index_o,
                            expected_color(line_addr, cfg_i, cur_h - H_BEGIN - 1));
            end else begin
                check_color("pf_color_index_o", pf_color_index_o,
                            border_color_i ^ cfg_i.colorbase);
            end
        end
        if (!reset_i && dma_ack_o) begin
            ack_count++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // extra cycle with end_of_frame where the new cfg takes effect
    task automatic start_frame(input pf_cfg_t cfg);
        @(posedge clk);
        #1;
        cfg_i             = cfg;
        end_of_frame_i    = 1'b1;
        end_of_line_i     = 1'b0;
        mem_fetch_i       = 1'b0;
        mem_fetch_start_i = 1'b0;
        h_count_i         = hcount_t'(LINE_CYC - 1);
        cur_h             = LINE_CYC - 1;
        line_addr         = cfg.start_addr;
    endtask

    // one line with an optional DMA request raised at h == dma_h
    task automatic run_line(input int dma_h, input addr_t dma_addr, output int ack_h);
        logic dma_active;
        dma_active = 1'b0;
        ack_h      = -1;
        for (int h = 0; h < LINE_CYC; h++) begin
            @(posedge clk);
            #1;
            h_count_i         = hcount_t'(h);
            cur_h             = h;
            mem_fetch_i       = (h >= 1) && (h <= 57);
            mem_fetch_start_i = (h == 0);
            end_of_line_i     = (h == LINE_CYC - 1);
            end_of_frame_i    = 1'b0;
            if (dma_active && dma_ack_o) begin
                ack_h = h;
                check_word("dma_word_o", dma_word_o, mem[dma_addr[11:0]]);
                dma_i      = '0;
                dma_active = 1'b0;
            end
            if (h == dma_h) begin
                dma_i.req  = 1'b1;
                dma_i.addr = dma_addr;
                dma_active = 1'b1;
            end
        end
        @(negedge clk);                         // after the compare of h 79
        if (!cfg_i.blank) begin
            line_addr = line_addr + cfg_i.line_len;
        end
        if (dma_active) begin
            n_errors++;
            $display("DMA request at %0t never acknowledged within its line", $time);
            dma_i = '0;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (n_errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_errors - errs_before);
        end
    endtask

    initial begin
        pf_cfg_t cfg;
        int      errs;
        int      ack_h;
        int      acks;
        h_count_i         = '0;
        mem_fetch_i       = 1'b0;
        mem_fetch_start_i = 1'b0;
        end_of_line_i     = 1'b0;
        end_of_frame_i    = 1'b0;
        border_color_i    = 8'h33;
        cfg_i             = '0;
        dma_i             = '0;
        vram_data_i       = '0;
        n_errors          = 0;
        n_checks          = 0;
        cycles            = 0;
        ack_count         = 0;
        cur_h             = 0;
        line_addr         = '0;
        checking          = 1'b0;
        seed              = 16784;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = word_t'($random(seed));
        end
        @(negedge reset_i);
        checking = 1'b1;

        errs = n_errors;                        // 8 bpp bytes
        cfg  = '{blank: 1'b0, start_addr: 16'h0010, line_len: 16'h0040,
                 colorbase: 8'h00, bpp: BPP_8};
        start_frame(cfg);
        run_line(-1, '0, ack_h);
        report_test("bpp8_line", errs);

        errs = n_errors;                        // 4 bpp nibbles with colour base
        cfg  = '{blank: 1'b0, start_addr: 16'h0200, line_len: 16'h0020,
                 colorbase: 8'h5a, bpp: BPP_4};
        start_frame(cfg);
        run_line(-1, '0, ack_h);
        report_test("bpp4_colorbase", errs);

        errs = n_errors;                        // 1 bpp fg/bg attribute
        cfg  = '{blank: 1'b0, start_addr: 16'h0300, line_len: 16'h0010,
                 colorbase: 8'h80, bpp: BPP_1_ATTR};
        start_frame(cfg);
        run_line(-1, '0, ack_h);
        report_test("bpp1_attr", errs);

        errs = n_errors;                        // line advance and frame reload
        cfg  = '{blank: 1'b0, start_addr: 16'h0400, line_len: 16'h0050,
                 colorbase: 8'h0f, bpp: BPP_8};
        start_frame(cfg);
        repeat (3) run_line(-1, '0, ack_h);
        start_frame(cfg);
        run_line(-1, '0, ack_h);
        report_test("line_advance_frame_reload", errs);

        errs = n_errors;                        // DMA outside and inside the window
        cfg  = '{blank: 1'b0, start_addr: 16'h0600, line_len: 16'h0040,
                 colorbase: 8'h00, bpp: BPP_8};
        start_frame(cfg);
        acks = ack_count;
        run_line(62, 16'h0123, ack_h);
        if (ack_h >= 0 && ack_h != 65) begin
            n_errors++;
            $display("DMA from idle acknowledged at h %0d instead of h 65", ack_h);
        end
        run_line(30, 16'h0456, ack_h);
        if (ack_h >= 0 && ack_h < 58) begin
            n_errors++;
            $display("DMA inside the window acknowledged early at h %0d", ack_h);
        end
        if (ack_count - acks != 2) begin
            n_errors++;
            $display("expected 2 DMA acknowledges, saw %0d", ack_count - acks);
        end
        report_test("dma_read", errs);

        errs = n_errors;                        // blank holds line address
        cfg  = '{blank: 1'b1, start_addr: 16'h0800, line_len: 16'h0030,
                 colorbase: 8'h21, bpp: BPP_4};
        start_frame(cfg);
        repeat (3) run_line(-1, '0, ack_h);
        report_test("blank_hold", errs);

        checking = 1'b0;
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- playfield_top.f
playfield_pkg.sv
pf_fetch.sv
pf_scan_timing.sv
pf_pixel_out.sv
playfield_top.sv
tb_clock_gen.sv
playfield_checker.sv
playfield_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= playfield_tb
FILELIST  ?= playfield_top.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
